// ==== edge_data_reader.sv ====
// Neighbor queue fed by edge-list responses
// Neighbor data read commands, one per queued neighbor

`timescale 1ns/10ps
`include "pagerank_defs.svh"

module edge_data_reader (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    rsp_valid,
	input  pagerank_pkg::read_rsp_t rsp,
	read_cmd_if.peer                data_cmd
);
	import pagerank_pkg::*;

	logic                  edge_hit;
	logic                  nbr_empty;
	logic                  nbr_pop;
	logic [`PR_ADDR_W-1:0] nbr_head;

	// Only edge-list responses carry a neighbor index
	assign edge_hit = rsp_valid && (rsp.kind == READ_EDGE);

	sync_fifo #(
		.T    (logic [`PR_ADDR_W-1:0]),
		.DEPTH(`NEIGHBOR_FIFO_DEPTH)
	) neighbor_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (edge_hit),
		.data_in (rsp.data[`PR_ADDR_W-1:0]),
		.pop     (nbr_pop),
		.data_out(nbr_head),
		.empty   (nbr_empty),
		.full    ()
	);

	//////////////////////////////////////////////////
	// Data command issue
	//////////////////////////////////////////////////

	// Head stays put until the arbiter takes it
	assign data_cmd.req = !nbr_empty;
	assign data_cmd.cmd = '{kind: READ_DATA, addr: nbr_head};
	assign nbr_pop      = data_cmd.req && data_cmd.ready;

endmodule

// ==== edge_job_reader.sv ====
// Vertex FIFO and current vertex register
// Edge-list read commands, one per edge of the current vertex

`timescale 1ns/10ps
`include "pagerank_defs.svh"

module edge_job_reader (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      vertex_valid,
	input  pagerank_pkg::vertex_job_t vertex_in,
	read_cmd_if.peer                  edge_cmd,
	input  logic                      vertex_done,
	output logic                      current_valid,
	output pagerank_pkg::vertex_job_t current_job
);
	import pagerank_pkg::*;

	logic                  vertex_empty;
	logic                  vertex_pop;
	vertex_job_t           vertex_head;
	logic [`PR_DEG_W-1:0]  edge_idx;
	logic [`PR_ADDR_W-1:0] edge_addr;

	sync_fifo #(
		.T    (vertex_job_t),
		.DEPTH(`VERTEX_FIFO_DEPTH)
	) vertex_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_valid),
		.data_in (vertex_in),
		.pop     (vertex_pop),
		.data_out(vertex_head),
		.empty   (vertex_empty),
		.full    ()
	);

	// Take the next vertex only when none is in flight
	assign vertex_pop = !current_valid && !vertex_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			current_valid <= 1'b0;
			edge_idx      <= '0;
		end else if (vertex_pop) begin
			current_valid <= 1'b1;
			edge_idx      <= '0;
		end else begin
			if (vertex_done) begin
				current_valid <= 1'b0;
			end
			if (edge_cmd.req && edge_cmd.ready) begin
				edge_idx <= edge_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (vertex_pop) begin
			current_job <= vertex_head;
		end
	end

	// Edge list walk
	assign edge_addr    = current_job.edge_base + `PR_ADDR_W'(edge_idx);
	assign edge_cmd.req = current_valid && (edge_idx != current_job.degree);
	assign edge_cmd.cmd = '{kind: READ_EDGE, addr: edge_addr};

endmodule

// ==== pagerank_cu.sv ====
// PageRank compute unit top level
// Flat ports packed into and out of the shared types
// Two read command channels, arbiter, readers and sum kernel

`timescale 1ns/10ps
`include "pagerank_defs.svh"

module pagerank_cu (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     vertex_valid,
	input  logic [`PR_VID_W-1:0]     vertex_id,
	input  logic [`PR_DEG_W-1:0]     vertex_degree,
	input  logic [`PR_ADDR_W-1:0]    vertex_edge_base,
	output logic                     read_cmd_request,
	input  logic                     read_cmd_grant,
	output logic                     read_cmd_valid,
	output pagerank_pkg::read_kind_t read_cmd_kind,
	output logic [`PR_ADDR_W-1:0]    read_cmd_addr,
	input  logic                     read_rsp_valid,
	input  pagerank_pkg::read_kind_t read_rsp_kind,
	input  logic [`PR_DATA_W-1:0]    read_rsp_data,
	output logic                     result_valid,
	output logic [`PR_VID_W-1:0]     result_vertex,
	output logic [`PR_DATA_W-1:0]    result_sum,
	output logic [`PR_CNT_W-1:0]     vertex_count,
	output logic [`PR_CNT_W-1:0]     edge_count
);
	import pagerank_pkg::*;

	vertex_job_t  vertex_in;
	vertex_job_t  current_job;
	read_cmd_t    read_cmd_out;
	read_rsp_t    rsp;
	rank_result_t result;
	logic         current_valid;
	logic         vertex_done;

	read_cmd_if edge_cmd ();
	read_cmd_if data_cmd ();

	// Flat port packing
	assign vertex_in     = '{id: vertex_id, degree: vertex_degree, edge_base: vertex_edge_base};
	assign rsp           = '{kind: read_rsp_kind, data: read_rsp_data};
	assign read_cmd_kind = read_cmd_out.kind;
	assign read_cmd_addr = read_cmd_out.addr;
	assign result_vertex = result.vertex;
	assign result_sum    = result.sum;

	read_cmd_arbiter arbiter (
		.clock           (clock),
		.rstn            (rstn),
		.edge_cmd        (edge_cmd),
		.data_cmd        (data_cmd),
		.read_cmd_request(read_cmd_request),
		.read_cmd_grant  (read_cmd_grant),
		.read_cmd_valid  (read_cmd_valid),
		.read_cmd_out    (read_cmd_out)
	);

	edge_job_reader job_reader (
		.clock        (clock),
		.rstn         (rstn),
		.vertex_valid (vertex_valid),
		.vertex_in    (vertex_in),
		.edge_cmd     (edge_cmd),
		.vertex_done  (vertex_done),
		.current_valid(current_valid),
		.current_job  (current_job)
	);

	edge_data_reader data_reader (
		.clock    (clock),
		.rstn     (rstn),
		.rsp_valid(read_rsp_valid),
		.rsp      (rsp),
		.data_cmd (data_cmd)
	);

	rank_sum_kernel sum_kernel (
		.clock        (clock),
		.rstn         (rstn),
		.rsp_valid    (read_rsp_valid),
		.rsp          (rsp),
		.current_valid(current_valid),
		.current_job  (current_job),
		.vertex_done  (vertex_done),
		.result_valid (result_valid),
		.result       (result),
		.vertex_count (vertex_count),
		.edge_count   (edge_count)
	);

endmodule

// ==== pagerank_defs.svh ====
// Widths and depths of the PageRank compute unit
// Address, data, vertex id, degree and counter widths
// Depths of the vertex, command and neighbor FIFOs

`ifndef PAGERANK_DEFS_SVH
`define PAGERANK_DEFS_SVH

// Bus and field widths
`define PR_ADDR_W 16
`define PR_DATA_W 32
`define PR_VID_W  16
`define PR_DEG_W  8
`define PR_CNT_W  32

// Queue depths
`define VERTEX_FIFO_DEPTH   8
`define CMD_FIFO_DEPTH      8
`define NEIGHBOR_FIFO_DEPTH 16

`endif

// ==== pagerank_pkg.sv ====
// Shared types of the PageRank compute unit
// Read kind, read command and read response
// Vertex job and rank result

`include "pagerank_defs.svh"

package pagerank_pkg;

	// Which array a read targets
	typedef enum logic {
		READ_EDGE = 1'b0,
		READ_DATA = 1'b1
	} read_kind_t;

	typedef struct packed {
		read_kind_t            kind;
		logic [`PR_ADDR_W-1:0] addr;
	} read_cmd_t;

	typedef struct packed {
		read_kind_t            kind;
		logic [`PR_DATA_W-1:0] data;
	} read_rsp_t;

	typedef struct packed {
		logic [`PR_VID_W-1:0]  id;
		logic [`PR_DEG_W-1:0]  degree;
		logic [`PR_ADDR_W-1:0] edge_base;
	} vertex_job_t;

	typedef struct packed {
		logic [`PR_VID_W-1:0]  vertex;
		logic [`PR_DATA_W-1:0] sum;
	} rank_result_t;

endpackage

// ==== pagerank_props.sv ====
// Concurrent assertions on the compute unit ports
// Command strobe timing, known strobes, result spacing
// Bound to the pagerank_cu module

`timescale 1ns/10ps

module pagerank_props (
	input logic clock,
	input logic rstn,
	input logic read_cmd_request,
	input logic read_cmd_grant,
	input logic read_cmd_valid,
	input logic result_valid
);

	// A command leaves only after a grant taken while requesting
	assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> $past(read_cmd_grant && read_cmd_request))
		else $error("read_cmd_valid without a granted request one cycle earlier");

	assert property (@(posedge clock) disable iff (!rstn)
		(read_cmd_grant && read_cmd_request) |=> read_cmd_valid)
		else $error("Granted request gave no read_cmd_valid");

	assert property (@(posedge clock) disable iff (!rstn)
		!$isunknown({read_cmd_request, read_cmd_valid, result_valid}))
		else $error("Output strobe unknown after reset");

	assert property (@(posedge clock) disable iff (!rstn)
		result_valid |=> !result_valid)
		else $error("result_valid high in two cycles in a row");

endmodule

bind pagerank_cu pagerank_props props (
	.clock           (clock),
	.rstn            (rstn),
	.read_cmd_request(read_cmd_request),
	.read_cmd_grant  (read_cmd_grant),
	.read_cmd_valid  (read_cmd_valid),
	.result_valid    (result_valid)
);

// ==== pagerank_tb.sv ====
// Testbench for the PageRank compute unit
// Vertex table with expected sums, memory model with random grants and gaps
// Command, result and counter checks, watchdog

`timescale 1ns/10ps
`include "pagerank_defs.svh"

module pagerank_tb;
	import pagerank_pkg::*;

	localparam int NUM_VERTICES   = 12;
	localparam int TIMEOUT_CYCLES = 200 * NUM_VERTICES + 1000;

	typedef struct packed {
		logic [`PR_VID_W-1:0]  id;
		logic [`PR_DEG_W-1:0]  degree;
		logic [`PR_ADDR_W-1:0] edge_base;
		logic [`PR_DATA_W-1:0] sum;
	} vertex_entry_t;

	logic                  clock;
	logic                  rstn;
	logic                  vertex_valid;
	logic [`PR_VID_W-1:0]  vertex_id;
	logic [`PR_DEG_W-1:0]  vertex_degree;
	logic [`PR_ADDR_W-1:0] vertex_edge_base;
	logic                  read_cmd_request;
	logic                  read_cmd_grant;
	logic                  read_cmd_valid;
	read_kind_t            read_cmd_kind;
	logic [`PR_ADDR_W-1:0] read_cmd_addr;
	logic                  read_rsp_valid;
	read_kind_t            read_rsp_kind;
	logic [`PR_DATA_W-1:0] read_rsp_data;
	logic                  result_valid;
	logic [`PR_VID_W-1:0]  result_vertex;
	logic [`PR_DATA_W-1:0] result_sum;
	logic [`PR_CNT_W-1:0]  vertex_count;
	logic [`PR_CNT_W-1:0]  edge_count;

	vertex_entry_t         vertex_table [NUM_VERTICES];
	logic [`PR_ADDR_W-1:0] expected_edges [$];
	logic [`PR_ADDR_W-1:0] returned [$];
	read_cmd_t             pending [$];
	logic [`PR_CNT_W-1:0]  total_edges;
	logic [31:0]           lfsr_state;
	logic [1:0]            gap;
	int                    results_seen;
	int                    sent;
	int                    edge_cmds_seen;
	int                    data_cmds_seen;
	int                    value_errors;
	int                    other_errors;

	pagerank_cu uut (
		.clock           (clock),
		.rstn            (rstn),
		.vertex_valid    (vertex_valid),
		.vertex_id       (vertex_id),
		.vertex_degree   (vertex_degree),
		.vertex_edge_base(vertex_edge_base),
		.read_cmd_request(read_cmd_request),
		.read_cmd_grant  (read_cmd_grant),
		.read_cmd_valid  (read_cmd_valid),
		.read_cmd_kind   (read_cmd_kind),
		.read_cmd_addr   (read_cmd_addr),
		.read_rsp_valid  (read_rsp_valid),
		.read_rsp_kind   (read_rsp_kind),
		.read_rsp_data   (read_rsp_data),
		.result_valid    (result_valid),
		.result_vertex   (result_vertex),
		.result_sum      (result_sum),
		.vertex_count    (vertex_count),
		.edge_count      (edge_count)
	);

	always #2 clock = ~clock;

	//////////////////////////////////////////////////
	// Memory model rules and random source
	//////////////////////////////////////////////////

	// Edge list entry at address a holds neighbor (7a + 3) mod 256
	function automatic logic [`PR_DATA_W-1:0] edge_neighbor(input logic [`PR_ADDR_W-1:0] a);
		logic [31:0] prod;
		prod = 32'(a) * 32'd7 + 32'd3;
		return `PR_DATA_W'(prod[7:0]);
	endfunction

	function automatic logic [`PR_DATA_W-1:0] neighbor_data(input logic [`PR_ADDR_W-1:0] n);
		return `PR_DATA_W'(n) * `PR_DATA_W'(1000) + `PR_DATA_W'(17);
	endfunction

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bit(output logic b);
		lfsr_state = lfsr_step(lfsr_state);
		b = lfsr_state[0];
	endtask

	task automatic set_entry(input int i, input int id, input int deg, input int base);
		logic [`PR_DATA_W-1:0] s;
		logic [`PR_ADDR_W-1:0] a;
		s = '0;
		for (int j = 0; j < deg; j++) begin
			a = `PR_ADDR_W'(base + j);
			expected_edges.push_back(a);
			s = s + neighbor_data(`PR_ADDR_W'(edge_neighbor(a)));
		end
		vertex_table[i] = '{id: `PR_VID_W'(id), degree: `PR_DEG_W'(deg),
			edge_base: `PR_ADDR_W'(base), sum: s};
		total_edges = total_edges + `PR_CNT_W'(deg);
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic compare_result(input string name, input rank_result_t exp,
			input rank_result_t act);
		if (act !== exp) begin
			value_errors++;
			$display("Error: %s expected vertex %h sum %h, actual vertex %h sum %h",
				name, exp.vertex, exp.sum, act.vertex, act.sum);
		end
	endtask

	task automatic compare_cmd(input string name, input read_cmd_t exp, input read_cmd_t act);
		if (act !== exp) begin
			value_errors++;
			$display("Error: %s expected %s at %h, actual %s at %h",
				name, exp.kind.name(), exp.addr, act.kind.name(), act.addr);
		end
	endtask

	task automatic compare_count(input string name, input logic [`PR_CNT_W-1:0] exp,
			input logic [`PR_CNT_W-1:0] act);
		if (act !== exp) begin
			value_errors++;
			$display("Error: %s expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("Error: %s expected %b, actual %b", name, exp, act);
		end
	endtask

	// Edge commands follow the table in order, data commands follow returned edges
	task automatic check_command(input read_cmd_t cmd);
		if (cmd.kind == READ_EDGE) begin
			if (expected_edges.size() == 0) begin
				other_errors++;
				$display("Edge-list read at %h when no edge was left to read", cmd.addr);
			end else begin
				compare_cmd($sformatf("edge command %0d", edge_cmds_seen),
					'{kind: READ_EDGE, addr: expected_edges.pop_front()}, cmd);
			end
			edge_cmds_seen++;
		end else begin
			if (returned.size() == 0) begin
				other_errors++;
				$display("Neighbor read at %h before any matching edge came back", cmd.addr);
			end else begin
				compare_cmd($sformatf("data command %0d", data_cmds_seen),
					'{kind: READ_DATA, addr: returned.pop_front()}, cmd);
			end
			data_cmds_seen++;
		end
	endtask

	task automatic send_response(input read_cmd_t cmd);
		read_rsp_kind = cmd.kind;
		if (cmd.kind == READ_EDGE) begin
			read_rsp_data = edge_neighbor(cmd.addr);
			returned.push_back(read_rsp_data[`PR_ADDR_W-1:0]);
		end else begin
			read_rsp_data = neighbor_data(cmd.addr);
		end
		read_rsp_valid = 1'b1;
	endtask

	//////////////////////////////////////////////////
	// Memory model on the falling edge
	//////////////////////////////////////////////////

	always @(negedge clock) begin : memory_model
		read_cmd_t cmd;
		logic      b0;
		logic      b1;
		if (!rstn) begin
			read_cmd_grant = 1'b0;
			read_rsp_valid = 1'b0;
		end else begin
			if (read_cmd_valid) begin
				cmd = '{kind: read_cmd_kind, addr: read_cmd_addr};
				check_command(cmd);
				pending.push_back(cmd);
			end
			if (result_valid) begin
				if (results_seen >= NUM_VERTICES) begin
					other_errors++;
					$display("Result for vertex %h after the last table entry", result_vertex);
				end else begin
					compare_result($sformatf("vertex %0d result", results_seen),
						'{vertex: vertex_table[results_seen].id,
						sum: vertex_table[results_seen].sum},
						'{vertex: result_vertex, sum: result_sum});
				end
				results_seen <= results_seen + 1;
			end
			read_cmd_grant = 1'b0;
			if (read_cmd_request) begin
				take_bit(b0);
				read_cmd_grant = b0;
			end
			read_rsp_valid = 1'b0;
			if (gap != 2'd0) begin
				gap = gap - 2'd1;
			end else if (pending.size() > 0) begin
				send_response(pending.pop_front());
				take_bit(b0);
				take_bit(b1);
				gap = {b1, b0};
			end
		end
	end

	//////////////////////////////////////////////////
	// Reset, stimulus loop and closing checks
	//////////////////////////////////////////////////

	initial begin
		clock            = 1'b0;
		rstn             = 1'b0;
		vertex_valid     = 1'b0;
		vertex_id        = '0;
		vertex_degree    = '0;
		vertex_edge_base = '0;
		read_cmd_grant   = 1'b0;
		read_rsp_valid   = 1'b0;
		read_rsp_kind    = READ_EDGE;
		read_rsp_data    = '0;
		lfsr_state       = 32'h1ec0;
		gap              = 2'd0;
		results_seen     = 0;
		sent             = 0;
		edge_cmds_seen   = 0;
		data_cmds_seen   = 0;
		value_errors     = 0;
		other_errors     = 0;
		total_edges      = '0;

		// id, degree, edge base
		set_entry(0, 16'h0001, 3, 16'h0000);
		set_entry(1, 16'h0002, 0, 16'h0010);
		set_entry(2, 16'h0003, 6, 16'h0020);
		set_entry(3, 16'h0004, 1, 16'h0035);
		set_entry(4, 16'h0005, 5, 16'h0100);
		set_entry(5, 16'h0006, 0, 16'h0200);
		set_entry(6, 16'h0007, 0, 16'h0300);
		set_entry(7, 16'h0008, 4, 16'h0abc);
		set_entry(8, 16'h0009, 2, 16'hfffe);
		set_entry(9, 16'h000a, 6, 16'h1234);
		set_entry(10, 16'h000b, 3, 16'h4000);
		set_entry(11, 16'h000c, 6, 16'h7777);

		repeat (3) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		compare_bit("read_cmd_request after reset", 1'b0, read_cmd_request);
		compare_bit("result_valid after reset", 1'b0, result_valid);
		compare_count("vertex_count after reset", '0, vertex_count);
		compare_count("edge_count after reset", '0, edge_count);

		for (int i = 0; i < NUM_VERTICES; i++) begin
			// Vertex FIFO must never overflow
			while ((sent - results_seen) >= `VERTEX_FIFO_DEPTH) begin
				@(negedge clock);
			end
			vertex_valid     = 1'b1;
			vertex_id        = vertex_table[i].id;
			vertex_degree    = vertex_table[i].degree;
			vertex_edge_base = vertex_table[i].edge_base;
			sent++;
			@(negedge clock);
			vertex_valid = 1'b0;
		end

		wait (results_seen == NUM_VERTICES);
		repeat (2) @(negedge clock);
		compare_count("final vertex_count", `PR_CNT_W'(NUM_VERTICES), vertex_count);
		compare_count("final edge_count", total_edges, edge_count);
		if (pending.size() != 0 || expected_edges.size() != 0 || returned.size() != 0) begin
			other_errors++;
			$display("Reads still outstanding after the last result");
		end

		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Timeout after %0d cycles with %0d of %0d results",
			TIMEOUT_CYCLES, results_seen, NUM_VERTICES);
		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== rank_sum_kernel.sv ====
// Sum of neighbor data for the current vertex
// Completion check against the degree, result strobe
// Completed-vertex and processed-edge counters

`timescale 1ns/10ps
`include "pagerank_defs.svh"

module rank_sum_kernel (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       rsp_valid,
	input  pagerank_pkg::read_rsp_t    rsp,
	input  logic                       current_valid,
	input  pagerank_pkg::vertex_job_t  current_job,
	output logic                       vertex_done,
	output logic                       result_valid,
	output pagerank_pkg::rank_result_t result,
	output logic [`PR_CNT_W-1:0]       vertex_count,
	output logic [`PR_CNT_W-1:0]       edge_count
);
	import pagerank_pkg::*;

	logic                  data_hit;
	logic                  done_cond;
	logic [`PR_DEG_W-1:0]  data_count;
	logic [`PR_DATA_W-1:0] sum;

	assign data_hit = rsp_valid && (rsp.kind == READ_DATA);

	// Blocked while the strobe is out, current clears the cycle after
	assign done_cond   = current_valid && !result_valid && (data_count == current_job.degree);
	assign vertex_done = result_valid;

	//////////////////////////////////////////////////
	// Accumulation
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum        <= '0;
			data_count <= '0;
		end else if (done_cond) begin
			sum        <= '0;
			data_count <= '0;
		end else if (data_hit) begin
			sum        <= sum + rsp.data;
			data_count <= data_count + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Result and counters
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			result_valid <= 1'b0;
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			result_valid <= done_cond;
			if (done_cond) begin
				vertex_count <= vertex_count + 1'b1;
			end
			if (data_hit) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (done_cond) begin
			result <= '{vertex: current_job.id, sum: sum};
		end
	end

endmodule

// ==== read_cmd_arbiter.sv ====
// Round-robin arbiter for the two read command peers
// Command FIFO between the arbiter and the external port
// External request/grant and registered command output

`timescale 1ns/10ps
`include "pagerank_defs.svh"

module read_cmd_arbiter (
	input  logic                    clock,
	input  logic                    rstn,
	read_cmd_if.arbiter             edge_cmd,
	read_cmd_if.arbiter             data_cmd,
	output logic                    read_cmd_request,
	input  logic                    read_cmd_grant,
	output logic                    read_cmd_valid,
	output pagerank_pkg::read_cmd_t read_cmd_out
);
	import pagerank_pkg::*;

	logic      last_data;
	logic      fifo_push;
	logic      fifo_pop;
	logic      fifo_empty;
	logic      fifo_full;
	read_cmd_t push_cmd;
	read_cmd_t fifo_out;

	//////////////////////////////////////////////////
	// Arbitration
	//////////////////////////////////////////////////

	// Edge peer wins a tie when data was served last
	assign edge_cmd.ready = !fifo_full && edge_cmd.req && (!data_cmd.req || last_data);
	assign data_cmd.ready = !fifo_full && data_cmd.req && (!edge_cmd.req || !last_data);

	assign fifo_push = edge_cmd.ready || data_cmd.ready;
	assign push_cmd  = edge_cmd.ready ? edge_cmd.cmd : data_cmd.cmd;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_data <= 1'b1;
		end else if (edge_cmd.ready) begin
			last_data <= 1'b0;
		end else if (data_cmd.ready) begin
			last_data <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Command FIFO and external port
	//////////////////////////////////////////////////

	sync_fifo #(
		.T    (read_cmd_t),
		.DEPTH(`CMD_FIFO_DEPTH)
	) cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (fifo_push),
		.data_in (push_cmd),
		.pop     (fifo_pop),
		.data_out(fifo_out),
		.empty   (fifo_empty),
		.full    (fifo_full)
	);

	assign read_cmd_request = !fifo_empty;

	// Grant without a pending request does nothing
	assign fifo_pop = read_cmd_grant && !fifo_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_cmd_valid <= 1'b0;
		end else begin
			read_cmd_valid <= fifo_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (fifo_pop) begin
			read_cmd_out <= fifo_out;
		end
	end

endmodule

// ==== read_cmd_if.sv ====
// Read command handshake between a reader and the arbiter
// Modports for the reader peer and for the arbiter

`timescale 1ns/10ps

interface read_cmd_if;
	import pagerank_pkg::*;

	// Transfer happens when req and ready are both high
	logic      req;
	logic      ready;
	read_cmd_t cmd;

	modport peer (
		output req,
		output cmd,
		input  ready
	);

	modport arbiter (
		input  req,
		input  cmd,
		output ready
	);

endinterface

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the outcome from the simulation log
verilator --binary --assert -Wno-fatal --top-module pagerank_tb -f tb.f -o pagerank_sim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/pagerank_sim > sim.log 2>&1 || echo "FAIL: see errors above" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

// ==== sync_fifo.sv ====
// Synchronous FIFO with a type parameter for the payload
// Circular buffer, registered count, show-ahead read data

`timescale 1ns/10ps
`include "pagerank_defs.svh"

module sync_fifo #(
	parameter type T     = pagerank_pkg::read_cmd_t,
	parameter int  DEPTH = `CMD_FIFO_DEPTH
) (
	input  logic clock,
	input  logic rstn,
	input  logic push,
	input  T     data_in,
	input  logic pop,
	output T     data_out,
	output logic empty,
	output logic full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	T              mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	// Wrap at DEPTH, which need not be a power of two
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		if (ptr == AW'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign empty    = (count == '0);
	assign full     = (count == CW'(DEPTH));
	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

endmodule

// ==== tb.f ====
+incdir+.
pagerank_pkg.sv
read_cmd_if.sv
sync_fifo.sv
read_cmd_arbiter.sv
edge_job_reader.sv
edge_data_reader.sv
rank_sum_kernel.sv
pagerank_cu.sv
pagerank_props.sv
pagerank_tb.sv
